//--- common/router_pkg.sv
package router_pkg;

   localparam int N_PORTS = 5;

   // Lowest port index has the highest priority
   localparam int PORT_LOCAL = 0;
   localparam int PORT_NORTH = 1;
   localparam int PORT_EAST  = 2;
   localparam int PORT_SOUTH = 3;
   localparam int PORT_WEST  = 4;

   typedef logic [1:0] coord_t;

   // Head flit layout; body flits reuse the 16 bits as plain data
   typedef struct packed {
      coord_t     dest_x;
      coord_t     dest_y;
      logic [3:0] body_len;
      logic [7:0] payload;
   } flit_t;

   localparam int FLIT_W = $bits(flit_t);

   ////////////////////////////////////////////////////////////
   // XY routing with X resolved before Y
   ////////////////////////////////////////////////////////////
   function automatic logic [2:0] xy_route(coord_t own_x, coord_t own_y, flit_t head);
      if (head.dest_x > own_x)
         return 3'(PORT_EAST);
      else if (head.dest_x < own_x)
         return 3'(PORT_WEST);
      else if (head.dest_y > own_y)
         return 3'(PORT_NORTH);
      else if (head.dest_y < own_y)
         return 3'(PORT_SOUTH);
      else
         return 3'(PORT_LOCAL);
   endfunction

endpackage

//--- common/port_if.sv
`timescale 1ns/10ps

interface port_if import router_pkg::*; ();

   // One-hot output request
   logic [N_PORTS-1:0] req;
   logic               gnt;
   // Flit leaves the input this cycle
   logic               send;
   flit_t              flit;

   modport inport (
      output req,
      output send,
      output flit,
      input  gnt
   );

   modport switch (
      input  req,
      input  send,
      input  flit,
      output gnt
   );

endinterface

//--- input_port/flit_fifo.sv
`timescale 1ns/10ps

module flit_fifo import router_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  wr_en,
   input  flit_t wr_flit,
   input  logic  rd_en,
   output flit_t rd_flit,
   output logic  full,
   output logic  empty
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [FLIT_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_wr;
   logic              do_rd;

   // Pointers wrap at FIFO_DEPTH even when it is not a power of two
   function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_wr   = wr_en && !full;
   assign do_rd   = rd_en && !empty;
   assign full    = (count == CNT_W'(FIFO_DEPTH));
   assign empty   = (count == '0);
   assign rd_flit = flit_t'(mem[rd_ptr]);

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_flit;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_rd)
            rd_ptr <= next_ptr(rd_ptr);
         // Simultaneous push and pop leaves the count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- input_port/flit_counter.sv
`timescale 1ns/10ps

module flit_counter
(
   input  logic       clk,
   input  logic       rst,
   input  logic       load,
   input  logic [3:0] load_len,
   input  logic       dec,
   output logic       active,
   output logic       at_tail
);

   // Body flits still to leave
   logic [3:0] count;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active <= 1'b0;
         count  <= '0;
      end
      else if (load)
      begin
         // Zero-length packet is already finished with its head
         active <= (load_len != 4'd0);
         count  <= load_len;
      end
      else if (dec && active)
      begin
         count <= count - 1'b1;
         if (count == 4'd1)
            active <= 1'b0;
      end
   end

   // When idle the pending head is also the tail if it has no body
   assign at_tail = active ? (count == 4'd1) : (load_len == 4'd0);

endmodule

//--- input_port/input_port.sv
`timescale 1ns/10ps

module input_port import router_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int ROUTER_X   = 1,
   parameter int ROUTER_Y   = 1
)
(
   input  logic   clk,
   input  logic   rst,
   input  logic   in_valid,
   input  flit_t  in_flit,
   output logic   in_ready,
   port_if.inport pif
);

   typedef enum logic [1:0] {
      WAIT_HEAD,
      SEND_PKT,
      RELEASE
   } state_t;

   state_t             state;
   state_t             next_state;
   flit_t              front;
   logic               full;
   logic               empty;
   logic               wr_en;
   logic               rd_en;
   logic [2:0]         head_route;
   logic [2:0]         route;
   logic [N_PORTS-1:0] req;
   logic               send;
   logic               load;
   logic               dec;
   logic               active;
   logic               at_tail;

   assign in_ready = !full;
   assign wr_en    = in_valid && !full;

   flit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (wr_en),
      .wr_flit (in_flit),
      .rd_en   (rd_en),
      .rd_flit (front),
      .full    (full),
      .empty   (empty)
   );

   // Inactive counter means the next send is the head
   assign load  = send && !active;
   assign dec   = send && active;
   assign rd_en = send;

   flit_counter u_cnt (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .load_len (front.body_len),
      .dec      (dec),
      .active   (active),
      .at_tail  (at_tail)
   );

   assign head_route = xy_route(coord_t'(ROUTER_X), coord_t'(ROUTER_Y), front);

   ////////////////////////////////////////////////////////////
   // Packet control
   ////////////////////////////////////////////////////////////

   // Route held for the body flits
   always_ff @(posedge clk)
   begin
      if (state == WAIT_HEAD && !empty)
         route <= head_route;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= WAIT_HEAD;
      else
         state <= next_state;
   end

   always_comb
   begin
      req        = '0;
      send       = 1'b0;
      next_state = state;
      case (state)
         WAIT_HEAD:
         begin
            // Request straight from the head at the front
            if (!empty)
            begin
               req        = N_PORTS'(1) << head_route;
               next_state = SEND_PKT;
            end
         end
         SEND_PKT:
         begin
            req = N_PORTS'(1) << route;
            if (pif.gnt && !empty)
            begin
               send = 1'b1;
               if (at_tail)
                  next_state = RELEASE;
            end
         end
         // Req low here lets the arbiter fall back to idle
         RELEASE:
            next_state = WAIT_HEAD;
         default:
            next_state = WAIT_HEAD;
      endcase
   end

   assign pif.req  = req;
   assign pif.send = send;
   assign pif.flit = front;

endmodule

//--- verilog/output_arbiter.sv
`timescale 1ns/10ps

module output_arbiter import router_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic [N_PORTS-1:0] req,
   output logic [N_PORTS-1:0] gnt
);

   // One-hot grant states with all zero as idle
   localparam logic [N_PORTS-1:0] IDLE = '0;

   logic [N_PORTS-1:0] state;
   logic [N_PORTS-1:0] next_state;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = IDLE;
      if (state == IDLE)
      begin
         // Scan top down so the lowest index wins
         for (int i = N_PORTS - 1; i >= 0; i--)
         begin
            if (req[i])
               next_state = N_PORTS'(1) << i;
         end
      end
      else if ((state & req) != IDLE)
      begin
         // Hold while the owner keeps asking
         next_state = state;
      end
   end

   // State bit i is the grant to requester i
   assign gnt = state;

endmodule

//--- verilog/crossbar.sv
`timescale 1ns/10ps

module crossbar import router_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [N_PORTS-1:0][N_PORTS-1:0] gnt,
   input  logic [N_PORTS-1:0]              send,
   input  flit_t [N_PORTS-1:0]             flit,
   output logic [N_PORTS-1:0]              out_valid,
   output flit_t [N_PORTS-1:0]             out_flit
);

   logic [N_PORTS-1:0]  sel_valid;
   flit_t [N_PORTS-1:0] sel_flit;

   // gnt[o] is one-hot over inputs
   always_comb
   begin
      for (int o = 0; o < N_PORTS; o++)
      begin
         sel_valid[o] = 1'b0;
         sel_flit[o]  = '0;
         for (int i = 0; i < N_PORTS; i++)
         begin
            if (gnt[o][i])
            begin
               sel_valid[o] = send[i];
               sel_flit[o]  = flit[i];
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= '0;
      else
         out_valid <= sel_valid;
   end

   always_ff @(posedge clk)
   begin
      out_flit <= sel_flit;
   end

endmodule

//--- verilog/router_top.sv
`timescale 1ns/10ps

module router_top import router_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int ROUTER_X   = 1,
   parameter int ROUTER_Y   = 1
)
(
   input  logic                clk,
   input  logic                rst,
   input  logic [N_PORTS-1:0]  in_valid,
   input  flit_t [N_PORTS-1:0] in_flit,
   output logic [N_PORTS-1:0]  in_ready,
   output logic [N_PORTS-1:0]  out_valid,
   output flit_t [N_PORTS-1:0] out_flit
);

   port_if pif [N_PORTS] ();

   // arb_req[o][i] is input i asking for output o
   wire [N_PORTS-1:0][N_PORTS-1:0] arb_req;
   wire [N_PORTS-1:0][N_PORTS-1:0] arb_gnt;
   // Grants regrouped by input
   wire [N_PORTS-1:0][N_PORTS-1:0] gnt_col;
   wire [N_PORTS-1:0]              sw_send;
   flit_t [N_PORTS-1:0]            sw_flit;

   ////////////////////////////////////////////////////////////
   // Input side
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < N_PORTS; i++)
   begin : g_in
      input_port #(
         .FIFO_DEPTH (FIFO_DEPTH),
         .ROUTER_X   (ROUTER_X),
         .ROUTER_Y   (ROUTER_Y)
      ) u_in (
         .clk      (clk),
         .rst      (rst),
         .in_valid (in_valid[i]),
         .in_flit  (in_flit[i]),
         .in_ready (in_ready[i]),
         .pif      (pif[i])
      );

      for (genvar o = 0; o < N_PORTS; o++)
      begin : g_xpose
         assign arb_req[o][i] = pif[i].req[o];
         assign gnt_col[i][o] = arb_gnt[o][i];
      end

      assign pif[i].gnt = |gnt_col[i];
      assign sw_send[i] = pif[i].send;
      assign sw_flit[i] = pif[i].flit;
   end

   ////////////////////////////////////////////////////////////
   // Output side
   ////////////////////////////////////////////////////////////
   for (genvar o = 0; o < N_PORTS; o++)
   begin : g_arb
      output_arbiter u_arb (
         .clk (clk),
         .rst (rst),
         .req (arb_req[o]),
         .gnt (arb_gnt[o])
      );
   end

   crossbar u_xbar (
      .clk       (clk),
      .rst       (rst),
      .gnt       (arb_gnt),
      .send      (sw_send),
      .flit      (sw_flit),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

endmodule

//--- tb/router_tb.sv
`timescale 1ns/10ps

module router_tb import router_pkg::*; ();

   localparam coord_t OWN_X = 2'd1;
   localparam coord_t OWN_Y = 2'd1;

   logic                clk;
   logic                rst;
   logic [N_PORTS-1:0]  in_valid;
   flit_t [N_PORTS-1:0] in_flit;
   logic [N_PORTS-1:0]  in_ready;
   logic [N_PORTS-1:0]  out_valid;
   flit_t [N_PORTS-1:0] out_flit;

   // Expected flits per output and per sending input
   flit_t       exp_q [N_PORTS][N_PORTS][$];
   // Bit 16 set marks an idle cycle before the next flit
   logic [16:0] tx_q [N_PORTS][$];

   int         errors = 0;
   int         pending = 0;
   int         flits_sent = 0;
   int         flits_checked = 0;
   int         tests_done = 0;
   logic [7:0] pkt_id = 8'd0;

   // Per-output packet tracking
   int                 owner [N_PORTS];
   int                 rem [N_PORTS];
   int                 first_owner [N_PORTS];
   logic [N_PORTS-1:0] stalled;

   // Falling edge captures for the assertions
   logic [N_PORTS-1:0] chk_en;
   logic [N_PORTS-1:0] chk_known;
   flit_t              chk_got [N_PORTS];
   flit_t              chk_exp [N_PORTS];
   logic [N_PORTS-1:0] chk_gnt [N_PORTS];
   logic [N_PORTS-1:0] chk_want [N_PORTS];

   router_top u_dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // XY rule with X resolved before Y
   function automatic int expected_port(coord_t dx, coord_t dy);
      if (dx > OWN_X)
         return PORT_EAST;
      if (dx < OWN_X)
         return PORT_WEST;
      if (dy > OWN_Y)
         return PORT_NORTH;
      if (dy < OWN_Y)
         return PORT_SOUTH;
      return PORT_LOCAL;
   endfunction

   task automatic queue_packet(int src, coord_t dx, coord_t dy, int len, int gap);
      flit_t head;
      flit_t body;
      int    outp;
      head.dest_x   = dx;
      head.dest_y   = dy;
      head.body_len = 4'(len);
      head.payload  = pkt_id;
      pkt_id        = pkt_id + 8'd1;
      outp          = expected_port(dx, dy);
      repeat (gap)
         tx_q[src].push_back(17'h10000);
      tx_q[src].push_back({1'b0, head});
      exp_q[outp][src].push_back(head);
      for (int k = 0; k < len; k++)
      begin
         body = flit_t'(16'($urandom));
         tx_q[src].push_back({1'b0, body});
         exp_q[outp][src].push_back(body);
      end
      flits_sent += len + 1;
      pending    += len + 1;
   endtask

   task automatic wait_drain();
      while (pending != 0)
         @(posedge clk);
      // A few idle cycles so stray flits still show up
      repeat (4)
         @(posedge clk);
   endtask

   task automatic report_test(string name);
      tests_done++;
      $display("test %0d %s finished, %0d errors so far", tests_done, name, errors);
   endtask

   ////////////////////////////////////////////////////////////
   // Input driver
   ////////////////////////////////////////////////////////////
   initial
   begin : driver
      logic [N_PORTS-1:0] took;
      in_valid = '0;
      in_flit  = '0;
      took     = '0;
      forever
      begin
         @(negedge clk);
         took    = in_valid & in_ready;
         stalled = stalled | (in_valid & ~in_ready);
         @(posedge clk);
         #1;
         for (int i = 0; i < N_PORTS; i++)
         begin
            if (took[i])
               void'(tx_q[i].pop_front());
            in_valid[i] = 1'b0;
            if (tx_q[i].size() > 0)
            begin
               if (tx_q[i][0][16])
                  void'(tx_q[i].pop_front());
               else
               begin
                  in_valid[i] = 1'b1;
                  in_flit[i]  = flit_t'(tx_q[i][0][15:0]);
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Output monitor and scoreboard
   ////////////////////////////////////////////////////////////
   always @(negedge clk)
   begin : monitor
      int    own;
      flit_t front;
      for (int o = 0; o < N_PORTS; o++)
      begin
         chk_en[o] = 1'b0;
         if (!rst && out_valid[o])
         begin
            own = owner[o];
            // A head tells which input owns the packet
            if (rem[o] == 0)
            begin
               own = -1;
               for (int i = N_PORTS - 1; i >= 0; i--)
               begin
                  if (exp_q[o][i].size() > 0 && exp_q[o][i][0] == out_flit[o])
                     own = i;
               end
               if (first_owner[o] < 0)
                  first_owner[o] = own;
            end
            chk_en[o]    = 1'b1;
            chk_known[o] = (own >= 0);
            chk_got[o]   = out_flit[o];
            chk_gnt[o]   = u_dut.arb_gnt[o];
            if (own >= 0)
            begin
               front          = exp_q[o][own][0];
               chk_exp[o]     = front;
               chk_want[o]    = '0;
               chk_want[o][own] = 1'b1;
               if (rem[o] == 0)
                  rem[o] = int'(front.body_len);
               else
                  rem[o] = rem[o] - 1;
               owner[o] = own;
               void'(exp_q[o][own].pop_front());
               pending--;
               flits_checked++;
            end
         end
      end
   end

   for (genvar o = 0; o < N_PORTS; o++)
   begin : g_chk
      assert property (@(posedge clk) chk_en[o] |-> chk_known[o])
      else
      begin
         errors++;
         $display("%0d ns: output %0d delivered a flit that no input sent to it", $time, o);
      end

      assert property (@(posedge clk) (chk_en[o] && chk_known[o]) |-> (chk_got[o] == chk_exp[o]))
      else
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: out_flit[%0d] expected %h got %h",
                  $time, o, chk_exp[o], chk_got[o]);
      end

      // Packet owner must keep the output until its tail
      assert property (@(posedge clk) (chk_en[o] && chk_known[o]) |-> (chk_gnt[o] == chk_want[o]))
      else
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: arb_gnt[%0d] expected %b got %b",
                  $time, o, chk_want[o], chk_gnt[o]);
      end
   end

   assert property (@(posedge clk) $past(rst) |-> (out_valid == '0))
   else
   begin
      errors++;
      $display("CHECK FAILED at %0d ns: out_valid expected %b got %b", $time, 5'b0, out_valid);
   end

   assert property (@(posedge clk) $past(rst) |-> (in_ready == '1))
   else
   begin
      errors++;
      $display("CHECK FAILED at %0d ns: in_ready expected %b got %b", $time, 5'b11111, in_ready);
   end

   // Limit grows with the traffic queued so far
   initial
   begin : watchdog
      int cycles = 0;
      while (cycles <= flits_sent * 40 + 500)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Watchdog timeout after %0d cycles, %0d flits never arrived", cycles, pending);
      $display("CHECKS FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial
   begin : main
      coord_t dst_x [N_PORTS] = '{2'd2, 2'd0, 2'd1, 2'd1, 2'd1};
      coord_t dst_y [N_PORTS] = '{2'd0, 2'd3, 2'd3, 2'd0, 2'd1};
      void'($urandom(34));
      for (int o = 0; o < N_PORTS; o++)
      begin
         owner[o]       = 0;
         rem[o]         = 0;
         first_owner[o] = -1;
      end
      stalled = '0;
      rst     = 1'b1;
      repeat (8)
         @(posedge clk);
      #1 rst = 1'b0;
      repeat (3)
         @(posedge clk);
      report_test("reset_state");

      // East, west, north, south and local from every input
      for (int s = 0; s < N_PORTS; s++)
      begin
         for (int d = 0; d < N_PORTS; d++)
         begin
            queue_packet(s, dst_x[d], dst_y[d], (s + d) % 4, 0);
            wait_drain();
         end
      end
      report_test("single_route");

      for (int o = 0; o < N_PORTS; o++)
         first_owner[o] = -1;
      queue_packet(1, 2'd3, 2'd2, 5, 0);
      queue_packet(3, 2'd3, 2'd2, 5, 0);
      wait_drain();
      assert (first_owner[PORT_EAST] == 1)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0d ns: first owner of east output expected 1 got %0d",
                  $time, first_owner[PORT_EAST]);
      end
      report_test("contention");

      stalled = '0;
      for (int k = 0; k < 3; k++)
      begin
         queue_packet(0, 2'd0, 2'd1, 7, 0);
         queue_packet(2, 2'd0, 2'd1, 7, 0);
      end
      wait_drain();
      assert (stalled[2])
      else
      begin
         errors++;
         $display("Input 2 was never held off by in_ready while its output was busy");
      end
      report_test("backpressure");

      queue_packet(0, 2'd2, 2'd1, 3, 0);
      queue_packet(1, 2'd0, 2'd1, 3, 0);
      queue_packet(2, 2'd1, 2'd2, 3, 0);
      queue_packet(3, 2'd1, 2'd0, 3, 0);
      queue_packet(4, 2'd1, 2'd1, 3, 0);
      wait_drain();
      report_test("parallel");

      for (int n = 0; n < 40; n++)
         queue_packet($urandom_range(4, 0), 2'($urandom), 2'($urandom),
                      $urandom_range(15, 0), $urandom_range(3, 0));
      wait_drain();
      report_test("random");

      for (int o = 0; o < N_PORTS; o++)
      begin
         for (int i = 0; i < N_PORTS; i++)
         begin
            assert (exp_q[o][i].size() == 0)
            else
            begin
               errors++;
               $display("%0d flits from input %0d never left output %0d",
                        exp_q[o][i].size(), i, o);
            end
         end
      end
      $display("tests %0d, flits sent %0d, flits checked %0d, errors %0d",
               tests_done, flits_sent, flits_checked, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- build.f
common/router_pkg.sv
common/port_if.sv
input_port/flit_fifo.sv
input_port/flit_counter.sv
input_port/input_port.sv
verilog/output_arbiter.sv
verilog/crossbar.sv
verilog/router_top.sv
tb/router_tb.sv

//--- build.sh
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/10ps \
   -f build.f --top-module router_tb -Mdir obj_dir -o router_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/router_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
